// ==== nes_load_pkg.sv ====
/*
 * Cartridge loader shared definitions
 * Address map constants, file kinds, loader states and bus structs
 */
package nes_load_pkg;

	////////////////////
	// Constants

	localparam int ADDR_W       = 22;   // Flat cartridge address space
	localparam int HEADER_BYTES = 16;
	localparam int PRG_SHIFT    = 14;   // 16 KiB PRG pages
	localparam int CHR_SHIFT    = 13;   // 8 KiB CHR pages
	localparam int PAL_BYTES    = 192;  // 64 entries of RGB

	// CHR data lives in the upper half
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h20_0000;

	localparam logic [7:0] RESET_HOLD = 8'd255;

	// iNES signature
	localparam logic [7:0] MAGIC0 = 8'h4E;  // N
	localparam logic [7:0] MAGIC1 = 8'h45;  // E
	localparam logic [7:0] MAGIC2 = 8'h53;  // S
	localparam logic [7:0] MAGIC3 = 8'h1A;

	////////////////////
	// Enums

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_ROM,
		KIND_CHEAT,
		KIND_PAL
	} file_kind_e;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_DONE
	} load_state_e;

	////////////////////
	// Structs

	// Download byte after the alignment register
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_byte_t;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_req_t;

	// Mapper flag word as seen by the console core
	typedef struct packed {
		logic       spare;
		logic       piano;
		logic [3:0] prg_ram;      // NES 2.0 shift count
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} cart_flags_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        we;
		logic [5:0]  index;
		logic [14:0] color;
	} pal_write_t;

endpackage

// ==== download_decode.sv ====
/*
 * Download front end
 * Classifies the file index, registers the byte stream and
 * holds the cartridge in reset around a ROM download
 */
module download_decode (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     dl_active,
	input  logic [7:0]               dl_index,
	input  logic                     dl_wr,
	input  logic [24:0]              dl_addr,
	input  logic [7:0]               dl_data,
	input  logic                     loader_busy,
	output nes_load_pkg::dl_byte_t   dl_byte,
	output nes_load_pkg::file_kind_e kind,
	output logic                     loader_start,
	output logic                     rom_active,
	output logic                     table_active,
	output logic                     cart_reset
);
	import nes_load_pkg::*;

	file_kind_e  kind_d;
	logic        wr_q;
	logic [24:0] addr_q;
	logic [7:0]  data_q;
	logic [7:0]  hold_cnt;

	// Cheat goes ahead of palette since all ones also ends in 11
	always_comb begin
		kind_d = KIND_NONE;
		if (dl_index[5:0] == 6'd0 && !dl_index[7])
			kind_d = KIND_ROM;
		else if (&dl_index)
			kind_d = KIND_CHEAT;
		else if (dl_index[1:0] == 2'b01 && dl_index[7:6] == 2'b00)
			kind_d = KIND_ROM;
		else if (dl_index[1:0] == 2'b11)
			kind_d = KIND_PAL;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_q         <= 1'b0;
			kind         <= KIND_NONE;
			table_active <= 1'b0;
			rom_active   <= 1'b0;
			loader_start <= 1'b0;
		end else begin
			wr_q         <= dl_wr;
			kind         <= kind_d;
			table_active <= dl_active;
			rom_active   <= dl_active && kind_d == KIND_ROM;
			loader_start <= dl_active && kind_d == KIND_ROM && !rom_active; // Rising edge
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= dl_addr;
		data_q <= dl_data;
	end

	assign dl_byte = '{wr: wr_q, addr: addr_q, data: data_q};

	// Post-download reset hold that pauses while the loader is busy
	always_ff @(posedge clk) begin
		if (reset_nes || rom_active)
			hold_cnt <= RESET_HOLD;
		else if (!loader_busy && hold_cnt != 8'd0)
			hold_cnt <= hold_cnt - 8'd1;
	end

	assign cart_reset = rom_active || hold_cnt != 8'd0;

endmodule

// ==== ines_loader.sv ====
/*
 * iNES ROM loader
 * Parses the 16 byte header, streams PRG and CHR data into the
 * cartridge space and builds the mapper flag word
 */
module ines_loader (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      loader_start,
	input  logic                      rom_active,
	input  logic                      invert_mirroring,
	input  nes_load_pkg::dl_byte_t    dl_byte,
	output nes_load_pkg::mem_req_t    mem,
	output nes_load_pkg::cart_flags_t flags,
	output logic                      busy,
	output logic                      done,
	output logic                      error
);
	import nes_load_pkg::*;

	load_state_e       state;
	logic [7:0]        ines [HEADER_BYTES];
	logic [3:0]        hdr_cnt;
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] bytes_left;
	logic              take;
	logic              hdr_take;
	logic              hdr_last;
	logic              mem_we;
	logic              sig_ok;
	logic [7:0]        prg_pages;
	logic [7:0]        chr_pages;
	logic [ADDR_W-1:0] prg_bytes;
	logic [ADDR_W-1:0] chr_bytes;
	logic              is_nes20;
	logic              is_dirty;
	cart_flags_t       flags_d;

	// Ceiling log2 of a page count capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--)
			if (pages <= (8'd1 << i))
				code = 3'(i);
		return code;
	endfunction

	assign take     = rom_active && dl_byte.wr;
	assign hdr_take = take && (loader_start || state == ST_HEADER);
	assign hdr_last = hdr_take && !loader_start && hdr_cnt == 4'(HEADER_BYTES - 1);

	assign prg_pages = ines[4];
	assign chr_pages = ines[5];
	assign prg_bytes = ADDR_W'(prg_pages) << PRG_SHIFT;
	assign chr_bytes = ADDR_W'(chr_pages) << CHR_SHIFT;

	// Trainers are not supported
	assign sig_ok = ines[0] == MAGIC0 && ines[1] == MAGIC1 &&
		ines[2] == MAGIC2 && ines[3] == MAGIC3 && !ines[6][2];

	// Write goes out in the same cycle as the byte
	assign mem_we = take && !loader_start && (state == ST_PRG || state == ST_CHR) &&
		bytes_left != '0;
	assign mem = '{we: mem_we, addr: addr_q, data: dl_byte.data};

	always_ff @(posedge clk) begin
		if (hdr_take)
			ines[loader_start ? 4'd0 : hdr_cnt] <= dl_byte.data;
	end

	////////////////////
	// Flag word

	assign is_nes20 = ines[7][3:2] == 2'b10;

	// Junk in bytes 9 to 15 of an old header
	assign is_dirty = !is_nes20 && (ines[9][7:1] != 7'd0 ||
		|{ines[10], ines[11], ines[12], ines[13], ines[14], ines[15]});

	always_comb begin
		flags_d             = '0;
		flags_d.piano       = is_nes20 && ines[15][5:0] == 6'h19;
		flags_d.prg_ram     = is_nes20 ? ines[10][3:0] : 4'h0;
		flags_d.has_saves   = ines[6][1];
		flags_d.submapper   = is_nes20 ? ines[8] : 8'h00;
		flags_d.four_screen = ines[6][3];
		flags_d.chr_ram     = chr_pages == 8'd0;
		flags_d.mirroring   = ines[6][0] ^ invert_mirroring;
		flags_d.chr_size    = size_code(chr_pages);
		flags_d.prg_size    = size_code(prg_pages);
		flags_d.mapper      = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
	end

	////////////////////
	// Load sequencer

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state   <= ST_HEADER;
			hdr_cnt <= 4'd0;
			busy    <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
			flags   <= '0;
		end else if (loader_start) begin
			state   <= ST_HEADER;
			hdr_cnt <= take ? 4'd1 : 4'd0;  // First byte may come with the start
			busy    <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
		end else begin
			case (state)
				ST_HEADER: begin
					if (hdr_take) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_last && sig_ok) begin
							state      <= ST_PRG;
							busy       <= 1'b1;
							addr_q     <= '0;
							bytes_left <= prg_bytes;
						end else if (hdr_last) begin
							state <= ST_ERROR;
						end
					end
				end
				ST_PRG: begin
					// Switch on the last PRG byte so a back-to-back CHR byte is kept
					if (bytes_left == '0 || (mem_we && bytes_left == ADDR_W'(1))) begin
						state      <= ST_CHR;
						addr_q     <= CHR_BASE;
						bytes_left <= chr_bytes;
					end else if (mem_we) begin
						addr_q     <= addr_q + 1'b1;
						bytes_left <= bytes_left - 1'b1;
					end
				end
				ST_CHR: begin
					if (bytes_left == '0) begin
						state <= ST_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
						flags <= flags_d;
					end else if (mem_we) begin
						addr_q     <= addr_q + 1'b1;
						bytes_left <= bytes_left - 1'b1;
					end
				end
				ST_ERROR: begin
					state <= ST_DONE;
					done  <= 1'b1;
					error <= 1'b1;
					flags <= flags_d;
				end
				default: ;  // Done holds until the next start
			endcase
		end
	end

endmodule

// ==== cheat_assembler.sv ====
/*
 * Cheat file assembler
 * Gathers 16 bytes into one flags/address/compare/replace code
 */
module cheat_assembler (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  nes_load_pkg::dl_byte_t    dl_byte,
	input  nes_load_pkg::file_kind_e  kind,
	input  logic                      table_active,
	output nes_load_pkg::cheat_code_t cheat,
	output logic                      cheat_valid
);
	import nes_load_pkg::*;

	logic       take;
	logic [3:0] k;
	logic [4:0] lane;

	assign take = table_active && dl_byte.wr && kind == KIND_CHEAT;
	assign k    = dl_byte.addr[3:0];
	assign lane = {k[1:0], 3'b000};  // Little endian within a field

	always_ff @(posedge clk) begin
		if (take) begin
			case (k[3:2])
				2'd0:    cheat.flags[lane +: 8]   <= dl_byte.data;
				2'd1:    cheat.address[lane +: 8] <= dl_byte.data;
				2'd2:    cheat.compare[lane +: 8] <= dl_byte.data;
				default: cheat.replace[lane +: 8] <= dl_byte.data;
			endcase
		end
	end

	// Code is complete once the last byte lands
	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= take && k == 4'd15;
	end

endmodule

// ==== palette_loader.sv ====
/*
 * Palette file loader
 * Packs RGB byte triples into 15-bit palette entry writes
 */
module palette_loader (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  nes_load_pkg::dl_byte_t   dl_byte,
	input  nes_load_pkg::file_kind_e kind,
	input  logic                     table_active,
	output nes_load_pkg::pal_write_t pal
);
	import nes_load_pkg::*;

	logic        take;
	logic [1:0]  lane_cnt;  // 0 red, 1 green, 2 blue
	logic [5:0]  entry;
	logic [9:0]  rg_q;
	logic        we_q;
	logic [5:0]  index_q;
	logic [14:0] color_q;

	assign take = table_active && dl_byte.wr && kind == KIND_PAL &&
		dl_byte.addr < 25'(PAL_BYTES);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			we_q     <= 1'b0;
			lane_cnt <= 2'd0;
			entry    <= 6'd0;
		end else begin
			we_q <= take && lane_cnt == 2'd2;
			if (!table_active) begin
				lane_cnt <= 2'd0;
				entry    <= 6'd0;
			end else if (take) begin
				lane_cnt <= (lane_cnt == 2'd2) ? 2'd0 : lane_cnt + 2'd1;
				if (lane_cnt == 2'd2)
					entry <= entry + 6'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (lane_cnt)
				2'd0: rg_q[4:0] <= dl_byte.data[7:3];
				2'd1: rg_q[9:5] <= dl_byte.data[7:3];
				default: begin
					color_q <= {dl_byte.data[7:3], rg_q};
					index_q <= entry;
				end
			endcase
		end
	end

	assign pal = '{we: we_q, index: index_q, color: color_q};

endmodule

// ==== cart_load_top.sv ====
/*
 * Cartridge load front end
 * Download decoder with the ROM, cheat and palette loaders
 */
module cart_load_top (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      dl_active,
	input  logic [7:0]                dl_index,
	input  logic                      dl_wr,
	input  logic [24:0]               dl_addr,
	input  logic [7:0]                dl_data,
	input  logic                      invert_mirroring,
	output nes_load_pkg::mem_req_t    mem,
	output nes_load_pkg::cart_flags_t flags,
	output logic                      loader_busy,
	output logic                      loader_done,
	output logic                      loader_error,
	output logic                      cart_reset,
	output nes_load_pkg::cheat_code_t cheat,
	output logic                      cheat_valid,
	output nes_load_pkg::pal_write_t  pal
);
	import nes_load_pkg::*;

	dl_byte_t   dl_byte;
	file_kind_e kind;
	logic       loader_start;
	logic       rom_active;
	logic       table_active;

	download_decode decode (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.loader_busy  (loader_busy),
		.dl_byte      (dl_byte),
		.kind         (kind),
		.loader_start (loader_start),
		.rom_active   (rom_active),
		.table_active (table_active),
		.cart_reset   (cart_reset)
	);

	ines_loader loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.loader_start     (loader_start),
		.rom_active       (rom_active),
		.invert_mirroring (invert_mirroring),
		.dl_byte          (dl_byte),
		.mem              (mem),
		.flags            (flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error)
	);

	cheat_assembler cheats (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.dl_byte      (dl_byte),
		.kind         (kind),
		.table_active (table_active),
		.cheat        (cheat),
		.cheat_valid  (cheat_valid)
	);

	palette_loader palette (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.dl_byte      (dl_byte),
		.kind         (kind),
		.table_active (table_active),
		.pal          (pal)
	);

endmodule

// ==== cart_load_asserts.sv ====
/*
 * Concurrent checks on the cartridge load top level
 */
module cart_load_asserts (
	input logic                   clk,
	input logic                   reset_nes,
	input nes_load_pkg::mem_req_t mem,
	input logic                   loader_busy,
	input logic                   loader_done,
	input logic                   cheat_valid
);

	// Cartridge writes belong to the PRG and CHR phases
	write_in_load: assert property (
		@(posedge clk) disable iff (reset_nes) mem.we |-> loader_busy
	) else $error("cartridge write while the loader is not busy");

	cheat_one_shot: assert property (
		@(posedge clk) disable iff (reset_nes) cheat_valid |=> !cheat_valid
	) else $error("cheat_valid high for two cycles in a row");

	busy_done_apart: assert property (
		@(posedge clk) disable iff (reset_nes) !(loader_busy && loader_done)
	) else $error("loader_busy and loader_done high together");

endmodule

// ==== tb_cart_load.sv ====
/*
 * Testbench for the cartridge load front end
 * Random ROM, cheat and palette downloads checked against a local model
 */
module tb_cart_load;
	import nes_load_pkg::*;

	localparam int GOOD_ROMS = 3;
	localparam int BAD_EXTRA = 32;   // Payload bytes sent after a bad header

	logic        clk = 1'b0;
	logic        reset_nes;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic        invert_mirroring;

	mem_req_t    mem;
	cart_flags_t flags;
	logic        loader_busy;
	logic        loader_done;
	logic        loader_error;
	logic        cart_reset;
	cheat_code_t cheat;
	logic        cheat_valid;
	pal_write_t  pal;

	logic [31:0] rng = 32'h6d2;
	logic [21:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	logic [20:0] exp_pal [$];    // {index, color}
	cheat_code_t exp_cheat;
	int          mem_writes;
	int          cheat_pulses;
	int          pal_writes;
	int          prg_pg [GOOD_ROMS];
	int          chr_pg [GOOD_ROMS];
	longint      watchdog_cycles;

	cart_load_top dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_active        (dl_active),
		.dl_index         (dl_index),
		.dl_wr            (dl_wr),
		.dl_addr          (dl_addr),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.mem              (mem),
		.flags            (flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error),
		.cart_reset       (cart_reset),
		.cheat            (cheat),
		.cheat_valid      (cheat_valid),
		.pal              (pal)
	);

	bind cart_load_top cart_load_asserts checks (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.mem         (mem),
		.loader_busy (loader_busy),
		.loader_done (loader_done),
		.cheat_valid (cheat_valid)
	);

	always #2 clk = ~clk;

	////////////////////
	// Helpers

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic value_mismatch(input string sig, input logic [127:0] got,
		input logic [127:0] want);
		$display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, want);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic fatal_error(input string what);
		$display("error at %0t: %s", $time, what);
		$display("sim failed");
		$fatal(1);
	endtask

	// Smallest c with 2**c >= pages up to 7
	function automatic logic [2:0] page_code(input logic [7:0] pages);
		int c;
		c = 0;
		while (c < 7 && (1 << c) < int'(pages))
			c++;
		return 3'(c);
	endfunction

	function automatic cart_flags_t model_flags(input logic [127:0] hdr, input logic inv);
		cart_flags_t f;
		logic [7:0]  b [16];
		bit          v2;
		bit          junk;
		for (int i = 0; i < 16; i++)
			b[i] = hdr[8*i +: 8];
		v2   = b[7][3] && !b[7][2];
		junk = 1'b0;
		if (!v2) begin
			if (b[9] > 8'd1)
				junk = 1'b1;
			for (int i = 10; i < 16; i++)
				if (b[i] != 8'd0)
					junk = 1'b1;
		end
		f             = '0;
		f.piano       = v2 && b[15][5:0] == 6'h19;
		f.prg_ram     = v2 ? b[10][3:0] : 4'd0;
		f.has_saves   = b[6][1];
		f.submapper   = v2 ? b[8] : 8'd0;
		f.four_screen = b[6][3];
		f.chr_ram     = b[5] == 8'd0;
		f.mirroring   = b[6][0] ^ inv;
		f.chr_size    = page_code(b[5]);
		f.prg_size    = page_code(b[4]);
		f.mapper      = {junk ? 4'd0 : b[7][7:4], b[6][7:4]};
		return f;
	endfunction

	// Mode 0 clean iNES, 1 NES 2.0, 2 old header with junk
	function automatic logic [127:0] make_header(input int mode, input logic [7:0] prg,
		input logic [7:0] chr);
		logic [7:0]   b [16];
		logic [31:0]  r;
		logic [127:0] h;
		for (int i = 0; i < 16; i++) begin
			r    = next_rand();
			b[i] = r[7:0];
		end
		b[0]    = MAGIC0;
		b[1]    = MAGIC1;
		b[2]    = MAGIC2;
		b[3]    = MAGIC3;
		b[4]    = prg;
		b[5]    = chr;
		b[6][2] = 1'b0;   // No trainer
		case (mode)
			0: begin
				b[7][3:2] = 2'b00;
				b[9]      = b[9] & 8'h01;
				for (int i = 10; i < 16; i++)
					b[i] = 8'h00;
			end
			1: begin
				b[7][3:2] = 2'b10;
				if (b[14][0])
					b[15] = 8'h19;
			end
			default: b[7][3] = 1'b0;
		endcase
		for (int i = 0; i < 16; i++)
			h[8*i +: 8] = b[i];
		return h;
	endfunction

	////////////////////
	// Stimulus

	task automatic open_download(input logic [7:0] index);
		dl_index  = index;
		dl_active = 1'b1;
		@(negedge clk);
	endtask

	// reset_level below zero skips the cart_reset check
	task automatic drive_byte(input logic [24:0] addr, input logic [7:0] data,
		input int reset_level);
		int          gap;
		logic [31:0] r;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk);
		dl_wr = 1'b0;
		r     = next_rand();
		gap   = int'(r % 4);
		repeat (gap) @(negedge clk);
		if (reset_level >= 0)
			assert (cart_reset == reset_level[0])
			else value_mismatch("cart_reset", 128'(cart_reset), 128'(reset_level));
	endtask

	task automatic wait_for_done(input int limit);
		int n;
		n = 0;
		while (!loader_done) begin
			if (n == limit)
				fatal_error("loader_done did not rise in time");
			else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	task automatic check_reset_hold();
		int n;
		n         = 0;
		dl_active = 1'b0;
		while (cart_reset && n <= int'(RESET_HOLD) + 4) begin
			@(negedge clk);
			n++;
		end
		assert (n >= int'(RESET_HOLD) && n <= int'(RESET_HOLD) + 4)
		else fatal_error($sformatf("cart_reset stayed high %0d cycles after the download",
			n));
	endtask

	task automatic send_rom(input logic [127:0] hdr, input logic inv, input bit good);
		int          prg_bytes;
		int          chr_bytes;
		int          total;
		int          exp_writes;
		logic [31:0] r;
		prg_bytes        = int'(hdr[39:32]) << PRG_SHIFT;
		chr_bytes        = int'(hdr[47:40]) << CHR_SHIFT;
		total            = good ? prg_bytes + chr_bytes : BAD_EXTRA;
		exp_writes       = good ? prg_bytes + chr_bytes : 0;
		mem_writes       = 0;
		invert_mirroring = inv;
		open_download(8'h00);
		for (int i = 0; i < HEADER_BYTES; i++)
			drive_byte(25'(i), hdr[8*i +: 8], 1);
		if (!good)
			wait_for_done(2);
		for (int i = 0; i < total; i++) begin
			r = next_rand();
			if (good) begin
				if (i < prg_bytes)
					exp_addr.push_back(22'(i));
				else
					exp_addr.push_back(CHR_BASE + 22'(i - prg_bytes));
				exp_data.push_back(r[7:0]);
			end
			drive_byte(25'(HEADER_BYTES + i), r[7:0], 1);
		end
		wait_for_done(8);
		assert (loader_error == !good)
		else value_mismatch("loader_error", 128'(loader_error), 128'(!good));
		assert (mem_writes == exp_writes)
		else value_mismatch("mem write count", 128'(mem_writes), 128'(exp_writes));
		assert (exp_addr.size() == 0)
		else fatal_error("expected cartridge writes never came");
		if (good)
			assert (flags == model_flags(hdr, inv))
			else value_mismatch("flags", 128'(flags), 128'(model_flags(hdr, inv)));
		check_reset_hold();
	endtask

	task automatic send_cheat();
		logic [31:0] field [4];
		logic [7:0]  bytes [16];
		logic [31:0] r;
		for (int k = 0; k < 16; k++) begin
			r        = next_rand();
			bytes[k] = r[7:0];
			field[k / 4][8 * (k % 4) +: 8] = bytes[k];
		end
		exp_cheat    = {field[0], field[1], field[2], field[3]};
		cheat_pulses = 0;
		open_download(8'hFF);
		for (int k = 0; k < 16; k++)
			drive_byte(25'(k), bytes[k], 0);
		repeat (3) @(negedge clk);
		dl_active = 1'b0;
		repeat (3) @(negedge clk);
		assert (cheat_pulses == 1)
		else value_mismatch("cheat_valid pulses", 128'(cheat_pulses), 128'(1));
	endtask

	task automatic send_palette();
		logic [7:0]  bytes [PAL_BYTES];
		logic [31:0] r;
		for (int i = 0; i < PAL_BYTES; i++) begin
			r        = next_rand();
			bytes[i] = r[7:0];
		end
		// Colour is blue, green, red from the top five bits
		for (int e = 0; e < PAL_BYTES / 3; e++)
			exp_pal.push_back({6'(e), bytes[3*e+2][7:3], bytes[3*e+1][7:3],
				bytes[3*e][7:3]});
		pal_writes = 0;
		open_download(8'h03);
		for (int i = 0; i < PAL_BYTES; i++)
			drive_byte(25'(i), bytes[i], 0);
		repeat (3) @(negedge clk);
		dl_active = 1'b0;
		repeat (3) @(negedge clk);
		assert (pal_writes == PAL_BYTES / 3)
		else value_mismatch("pal write count", 128'(pal_writes), 128'(PAL_BYTES / 3));
	endtask

	////////////////////
	// Output monitor

	always @(negedge clk) begin
		if (!reset_nes) begin
			if (mem.we) begin
				assert (exp_addr.size() != 0)
				else fatal_error("cartridge write with none due");
				assert (mem.addr == exp_addr[0])
				else value_mismatch("mem.addr", 128'(mem.addr), 128'(exp_addr[0]));
				assert (mem.data == exp_data[0])
				else value_mismatch("mem.data", 128'(mem.data), 128'(exp_data[0]));
				exp_addr.delete(0);
				exp_data.delete(0);
				mem_writes++;
			end
			if (cheat_valid) begin
				cheat_pulses++;
				assert (cheat == exp_cheat) else value_mismatch("cheat", cheat, exp_cheat);
			end
			if (pal.we) begin
				assert (exp_pal.size() != 0)
				else fatal_error("palette write with none due");
				assert (pal.index == exp_pal[0][20:15])
				else value_mismatch("pal.index", 128'(pal.index), 128'(exp_pal[0][20:15]));
				assert (pal.color == exp_pal[0][14:0])
				else value_mismatch("pal.color", 128'(pal.color), 128'(exp_pal[0][14:0]));
				exp_pal.delete(0);
				pal_writes++;
			end
		end
	end

	////////////////////
	// Main sequence

	initial begin
		logic [127:0] hdr;
		logic [31:0]  r;
		int           total;
		reset_nes        = 1'b1;
		dl_active        = 1'b0;
		dl_index         = 8'h00;
		dl_wr            = 1'b0;
		dl_addr          = '0;
		dl_data          = 8'h00;
		invert_mirroring = 1'b0;
		total            = 0;
		for (int g = 0; g < GOOD_ROMS; g++) begin
			r         = next_rand();
			prg_pg[g] = 1 + int'(r % 4);
			r         = next_rand();
			chr_pg[g] = 1 + int'(r % 4);
			total += HEADER_BYTES + (prg_pg[g] << PRG_SHIFT) + (chr_pg[g] << CHR_SHIFT);
		end
		total += 2 * (HEADER_BYTES + BAD_EXTRA) + 16 + PAL_BYTES;
		// Up to four cycles per byte plus the reset hold of each download
		watchdog_cycles = longint'(total) * 4 + 7 * 400 + 200;

		repeat (4) @(negedge clk);
		reset_nes = 1'b0;
		assert (!mem.we && !cheat_valid && !pal.we && !loader_busy && !loader_done &&
			!loader_error) else fatal_error("outputs not idle after reset");
		assert (cart_reset) else fatal_error("cart_reset low after reset");

		for (int g = 0; g < GOOD_ROMS; g++) begin
			r   = next_rand();
			hdr = make_header(g % 3, 8'(prg_pg[g]), 8'(chr_pg[g]));
			send_rom(hdr, r[0], 1'b1);
		end

		// Corrupt one signature byte
		r   = next_rand();
		hdr = make_header(0, 8'd1, 8'd1);
		hdr[8 * int'(r % 4) +: 8] = hdr[8 * int'(r % 4) +: 8] ^ 8'h20;
		send_rom(hdr, 1'b0, 1'b0);

		hdr     = make_header(0, 8'd1, 8'd1);
		hdr[50] = 1'b1;   // Trainer present
		send_rom(hdr, 1'b0, 1'b0);

		send_cheat();
		send_palette();

		$display("sim passed");
		$finish;
	end

	initial begin
		#1;
		#(watchdog_cycles * 4);
		$display("error at %0t: watchdog expired before the run finished", $time);
		$display("sim failed");
		$fatal(1);
	end

endmodule

// ==== all.f ====
nes_load_pkg.sv
download_decode.sv
ines_loader.sv
cheat_assembler.sv
palette_loader.sv
cart_load_top.sv
cart_load_asserts.sv
tb_cart_load.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cartridge loader testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --assert -Wno-fatal -f all.f --top-module tb_cart_load -o tb_cart_load &&
	./obj_dir/tb_cart_load || exit 1
